//--- src/board_pkg.sv
`default_nettype none

package board_pkg;

    // bus widths seen by the cpu side
    parameter int addr_width = 64;
    parameter int data_width = 64;

    // memory mapped io, top of the 64k window
    parameter logic [addr_width-1:0] key_addr     = 64'h0000_0000_0000_FFFE;
    parameter logic [addr_width-1:0] console_addr = 64'h0000_0000_0000_FFFF;

    // ps2 set 2 break prefix
    parameter logic [7:0] break_prefix = 8'hF0;

    // one cpu request, valid whenever we or re is high
    typedef struct packed {
        logic [addr_width-1:0] address;
        logic [data_width-1:0] wdata;
        logic                  we;
        logic                  re;
    } bus_req_t;

    // one decoded key event from the ps2 receiver
    // valid is a single cycle pulse
    typedef struct packed {
        logic       valid;
        logic       released;
        logic [7:0] code;
    } key_event_t;

    // interrupt vector, 0 means nothing pending
    typedef logic [3:0] irq_vector_t;

endpackage

`default_nettype wire

//--- src/clock_divider.sv
`timescale 1ns/1ps
`default_nettype none

module clock_divider #(
    parameter int DIVIDE = 25_000_000
) (
    input  logic CLOCK_50,
    input  logic KEY0,
    output logic cpu_tick,
    output logic heartbeat
);

    // counter must hold DIVIDE-1, at least one bit
    localparam int cw = (DIVIDE > 1) ? $clog2(DIVIDE) : 1;
    localparam logic [cw-1:0] last = cw'(DIVIDE - 1);

    logic [cw-1:0] count;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            count     <= '0;
            cpu_tick  <= 1'b0;
            heartbeat <= 1'b0;
        end else if (count == last) begin
            // wrap, one tick and flip the led
            count     <= '0;
            cpu_tick  <= 1'b1;
            heartbeat <= ~heartbeat;
        end else begin
            count    <= count + 1'b1;
            cpu_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- src/ps2_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  logic                    ps2_clk,
    input  logic                    ps2_dat,
    output board_pkg::key_event_t   key_event
);

    typedef enum logic [1:0] {
        st_idle,
        st_data,
        st_parity,
        st_stop
    } state_t;

    state_t     state;
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    logic       clk_prev;
    logic       clk_fall;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       parity_ok;
    logic       break_pending;

    // two flop synchronizers, both lines are async to CLOCK_50
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    // device changes data on rising edge, we sample on falling
    assign clk_fall = clk_prev && !clk_sync[1];

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            state         <= st_idle;
            bit_cnt       <= '0;
            shift         <= '0;
            parity_ok     <= 1'b0;
            break_pending <= 1'b0;
            key_event     <= '0;
        end else begin
            // valid is a pulse
            key_event.valid <= 1'b0;
            if (clk_fall) begin
                case (state)
                    st_idle: begin
                        // start bit is low
                        if (!dat_sync[1]) begin
                            state   <= st_data;
                            bit_cnt <= '0;
                        end
                    end
                    st_data: begin
                        // lsb first
                        shift   <= {dat_sync[1], shift[7:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= st_parity;
                        end
                    end
                    st_parity: begin
                        // odd parity over data plus parity bit
                        parity_ok <= ^{shift, dat_sync[1]};
                        state     <= st_stop;
                    end
                    default: begin
                        state <= st_idle;
                        // stop bit high and parity good, else drop
                        if (dat_sync[1] && parity_ok) begin
                            if (shift == board_pkg::break_prefix) begin
                                break_pending <= 1'b1;
                            end else begin
                                key_event.valid    <= 1'b1;
                                key_event.released <= break_pending;
                                key_event.code     <= shift;
                                break_pending      <= 1'b0;
                            end
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- src/board_memory.sv
`timescale 1ns/1ps
`default_nettype none

module board_memory #(
    parameter int MEM_WORDS = 2048
) (
    input  logic                         CLOCK_50,
    input  logic                         we,
    input  logic                         re,
    input  logic [$clog2(MEM_WORDS)-1:0] index,
    input  logic [31:0]                  wdata,
    output logic [31:0]                  rdata
);

    // boot and program space share one array
    logic [31:0] mem [MEM_WORDS];

    // single port, write and read never collide on the bus
    always_ff @(posedge CLOCK_50) begin
        if (we) begin
            mem[index] <= wdata;
        end
        // registered read, holds until the next re
        if (re) begin
            rdata <= mem[index];
        end
    end

endmodule

`default_nettype wire

//--- src/bus_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
    parameter int MEM_WORDS = 2048
) (
    input  logic                                  CLOCK_50,
    input  logic                                  KEY0,
    input  board_pkg::bus_req_t                   bus_req,
    input  board_pkg::key_event_t                 key_event,
    output logic                                  mem_we,
    output logic                                  mem_re,
    output logic [$clog2(MEM_WORDS)-1:0]          mem_index,
    output logic [31:0]                           mem_wdata,
    input  logic [31:0]                           mem_rdata,
    output logic [board_pkg::data_width-1:0]      bus_rdata,
    output logic                                  console_strobe,
    output logic [7:0]                            console_data,
    output logic [7:0]                            ledg
);

    localparam int iw = $clog2(MEM_WORDS);
    // first byte address past the memory
    localparam logic [board_pkg::addr_width-1:0] mem_limit =
        {{(board_pkg::addr_width-32){1'b0}}, 32'(MEM_WORDS * 4)};

    logic       mem_sel;
    logic       key_sel;
    logic       con_wr;
    logic       con_wr_d;
    logic       rd_mem;
    logic       rd_key;
    logic [7:0] key_reg;
    logic [7:0] key_snap;

    // address decode
    assign mem_sel = bus_req.address < mem_limit;
    assign key_sel = bus_req.address == board_pkg::key_addr;
    assign con_wr  = bus_req.we && (bus_req.address == board_pkg::console_addr);

    // memory side, word index is byte address / 4
    assign mem_we    = bus_req.we && mem_sel;
    assign mem_re    = bus_req.re && mem_sel;
    assign mem_index = bus_req.address[iw+1:2];
    assign mem_wdata = bus_req.wdata[31:0];

    // remember which region the last read hit
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            rd_mem <= 1'b0;
            rd_key <= 1'b0;
        end else if (bus_req.re) begin
            rd_mem <= mem_sel;
            rd_key <= key_sel;
        end
    end

    // keyboard register, make events with a real code only
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_reg <= '0;
        end else if (key_event.valid && !key_event.released && key_event.code != 8'h00) begin
            key_reg <= key_event.code;
        end
    end

    assign ledg = key_reg;

    // console strobe on the first write of a run
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            con_wr_d       <= 1'b0;
            console_strobe <= 1'b0;
        end else begin
            con_wr_d       <= con_wr;
            console_strobe <= con_wr && !con_wr_d;
        end
    end

    // data regs, only meaningful after their strobe or read
    always_ff @(posedge CLOCK_50) begin
        if (con_wr && !con_wr_d) begin
            console_data <= bus_req.wdata[7:0];
        end
        // snapshot so read data holds while the key register moves
        if (bus_req.re && key_sel) begin
            key_snap <= key_reg;
        end
    end

    // read mux, unmapped reads give zero
    always_comb begin
        if (rd_mem) begin
            bus_rdata = {{(board_pkg::data_width-32){1'b0}}, mem_rdata};
        end else if (rd_key) begin
            bus_rdata = {{(board_pkg::data_width-8){1'b0}}, key_snap};
        end else begin
            bus_rdata = '0;
        end
    end

endmodule

`default_nettype wire

//--- src/interrupt_controller.sv
`timescale 1ns/1ps
`default_nettype none

module interrupt_controller (
    input  logic                    CLOCK_50,
    input  logic                    KEY0,
    input  board_pkg::key_event_t   key_event,
    input  logic                    irq_ack,
    output board_pkg::irq_vector_t  irq_vector,
    output logic                    irq_led
);

    logic key_set;
    logic ack_clr;

    // only a make with nonzero code raises the keyboard irq
    assign key_set = key_event.valid && !key_event.released && key_event.code != 8'h00;
    // ack only counts while something is pending
    assign ack_clr = (irq_vector != '0) && irq_ack;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_vector <= '0;
        end else if (ack_clr) begin
            // clear wins, so each irq is delivered once
            irq_vector <= '0;
        end else if (key_set) begin
            // keyboard is vector 1
            irq_vector <= board_pkg::irq_vector_t'(1);
        end
    end

    assign irq_led = irq_vector != '0;

endmodule

`default_nettype wire

//--- src/cpu_board_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_board_top #(
    parameter int DIVIDE    = 25_000_000,
    parameter int MEM_WORDS = 2048
) (
    input  logic                               CLOCK_50,
    input  logic                               KEY0,
    input  logic                               PS2_CLK,
    input  logic                               PS2_DAT,
    input  board_pkg::bus_req_t                bus_req,
    input  logic                               irq_ack,
    output logic [board_pkg::data_width-1:0]   bus_rdata,
    output board_pkg::irq_vector_t             irq_vector,
    output logic                               console_strobe,
    output logic [7:0]                         console_data,
    output logic [7:0]                         LEDG,
    output logic                               LEDR9,
    output logic                               LEDR7,
    output logic                               cpu_tick
);

    board_pkg::key_event_t          key_event;
    logic                           mem_we;
    logic                           mem_re;
    logic [$clog2(MEM_WORDS)-1:0]   mem_index;
    logic [31:0]                    mem_wdata;
    logic [31:0]                    mem_rdata;

    // slow cpu tick, heartbeat on the leftmost red led
    clock_divider #(
        .DIVIDE(DIVIDE)
    ) i_clock_divider (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .cpu_tick (cpu_tick),
        .heartbeat(LEDR9)
    );

    // keyboard port
    ps2_receiver i_ps2_receiver (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .ps2_clk  (PS2_CLK),
        .ps2_dat  (PS2_DAT),
        .key_event(key_event)
    );

    // boot plus program memory
    board_memory #(
        .MEM_WORDS(MEM_WORDS)
    ) i_board_memory (
        .CLOCK_50(CLOCK_50),
        .we      (mem_we),
        .re      (mem_re),
        .index   (mem_index),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata)
    );

    bus_decoder #(
        .MEM_WORDS(MEM_WORDS)
    ) i_bus_decoder (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .key_event     (key_event),
        .mem_we        (mem_we),
        .mem_re        (mem_re),
        .mem_index     (mem_index),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .bus_rdata     (bus_rdata),
        .console_strobe(console_strobe),
        .console_data  (console_data),
        .ledg          (LEDG)
    );

    // irq status on red led 7
    interrupt_controller i_interrupt_controller (
        .CLOCK_50  (CLOCK_50),
        .KEY0      (KEY0),
        .key_event (key_event),
        .irq_ack   (irq_ack),
        .irq_vector(irq_vector),
        .irq_led   (LEDR7)
    );

endmodule

`default_nettype wire

//--- testbench/cpu_board_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_board_assertions #(
    parameter bit irq_side = 1'b0
) (
    input logic                   CLOCK_50,
    input logic                   KEY0,
    input logic                   strobe,
    input logic                   we,
    input logic                   re,
    input logic                   irq_ack,
    input board_pkg::irq_vector_t irq_vector
);

    int failures = 0;

    if (irq_side) begin : g_irq
        // pending vector gone the cycle after an ack
        ack_clears: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
            (irq_vector != '0 && irq_ack) |=> irq_vector == '0)
            else begin
                $error("irq vector not cleared after acknowledge");
                failures++;
            end
    end else begin : g_bus
        // console strobe is a one cycle pulse
        strobe_single: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
            strobe |=> !strobe)
            else begin
                $error("console strobe high two cycles in a row");
                failures++;
            end

        // cpu never reads and writes at once
        we_re_exclusive: assert property (@(posedge CLOCK_50) disable iff (!KEY0)
            !(we && re))
            else begin
                $error("bus write and read enable high together");
                failures++;
            end
    end

endmodule

// decoder side, irq inputs tied off
bind bus_decoder cpu_board_assertions #(
    .irq_side(1'b0)
) i_decoder_assertions (
    .CLOCK_50  (CLOCK_50),
    .KEY0      (KEY0),
    .strobe    (console_strobe),
    .we        (bus_req.we),
    .re        (bus_req.re),
    .irq_ack   (1'b0),
    .irq_vector(4'h0)
);

// interrupt side, bus inputs tied off
bind interrupt_controller cpu_board_assertions #(
    .irq_side(1'b1)
) i_irq_assertions (
    .CLOCK_50  (CLOCK_50),
    .KEY0      (KEY0),
    .strobe    (1'b0),
    .we        (1'b0),
    .re        (1'b0),
    .irq_ack   (irq_ack),
    .irq_vector(irq_vector)
);

`default_nettype wire

//--- testbench/cpu_board_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_board_checker #(
    parameter int DIVIDE    = 8,
    parameter int MEM_WORDS = 64
) (
    input  logic                     CLOCK_50,
    input  logic                     KEY0,
    input  board_pkg::bus_req_t      bus_req,
    input  logic                     irq_ack,
    input  logic                     ps2_clk,
    input  logic [7:0]               frame_code,
    input  logic                     frame_is_make,
    input  logic [8*16-1:0]          test_name,
    input  logic [63:0]              bus_rdata,
    input  board_pkg::irq_vector_t   irq_vector,
    input  logic                     console_strobe,
    input  logic [7:0]               console_data,
    input  logic [7:0]               ledg,
    input  logic                     ledr9,
    input  logic                     ledr7,
    input  logic                     cpu_tick,
    output int                       error_count
);

    localparam logic [63:0] mem_bytes = 64'(MEM_WORDS * 4);

    // reference model of the board
    logic [31:0]            mem_model [MEM_WORDS];
    logic                   mem_known [MEM_WORDS];
    logic [7:0]             key_model;
    board_pkg::irq_vector_t irq_model;
    logic                   con_wr;
    logic                   con_prev;
    logic                   strobe_exp;
    logic                   con_data_valid;
    logic [7:0]             con_data_exp;
    logic                   rd_pending;
    logic                   rd_known;
    logic [63:0]            rd_exp;
    int                     div_cnt;
    logic                   tick_exp;
    logic                   hb_exp;
    logic                   ps2_prev;
    int                     fall_cnt;
    int                     frame_wait;
    logic                   key_set;
    logic                   ack_now;
    int                     idx;
    logic [8*16-1:0]        name_q;
    int                     errors = 0;

    assign error_count = errors;

    task automatic check_value(input string what, input logic [63:0] exp,
                               input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("Mismatch %0s %0s: expected %h actual %h", name_q, what, exp, act);
        end
    endtask

    // model steps on the same edge as the dut
    always @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem_known[i] = 1'b0;
            end
            key_model      = '0;
            irq_model      = '0;
            con_prev       = 1'b0;
            strobe_exp     = 1'b0;
            con_data_valid = 1'b0;
            rd_pending     = 1'b0;
            div_cnt        = 0;
            tick_exp       = 1'b0;
            hb_exp         = 1'b0;
            ps2_prev       = 1'b1;
            fall_cnt       = 0;
            frame_wait     = 0;
            name_q         = test_name;
        end else begin
            name_q = test_name;
            // expected read data, shows up one cycle later
            rd_pending = bus_req.re;
            rd_known   = 1'b1;
            if (bus_req.re) begin
                if (bus_req.address < mem_bytes) begin
                    idx      = int'(bus_req.address / 64'd4);
                    rd_known = mem_known[idx];
                    rd_exp   = {32'h0, mem_model[idx]};
                end else if (bus_req.address == board_pkg::key_addr) begin
                    rd_exp = {56'h0, key_model};
                end else begin
                    rd_exp = '0;
                end
            end
            // only the low word is stored
            if (bus_req.we && bus_req.address < mem_bytes) begin
                idx            = int'(bus_req.address / 64'd4);
                mem_model[idx] = bus_req.wdata[31:0];
                mem_known[idx] = 1'b1;
            end
            // first write of a console run
            con_wr     = bus_req.we && (bus_req.address == board_pkg::console_addr);
            strobe_exp = con_wr && !con_prev;
            if (strobe_exp) begin
                con_data_exp   = bus_req.wdata[7:0];
                con_data_valid = 1'b1;
            end
            con_prev = con_wr;
            // tick every DIVIDE cycles
            tick_exp = (div_cnt == DIVIDE - 1);
            div_cnt  = tick_exp ? 0 : div_cnt + 1;
            if (tick_exp) begin
                hb_exp = !hb_exp;
            end
            // key event lands 3 cycles after the last fall, register one later
            ack_now = (irq_model != '0) && irq_ack;
            key_set = 1'b0;
            if (frame_wait > 0) begin
                frame_wait--;
                if (frame_wait == 0 && frame_is_make && frame_code != 8'h00) begin
                    key_set = 1'b1;
                end
            end
            if (key_set) begin
                key_model = frame_code;
            end
            // clear beats set
            if (ack_now) begin
                irq_model = '0;
            end else if (key_set) begin
                irq_model = board_pkg::irq_vector_t'(1);
            end
            // eleven falls per frame
            if (ps2_prev && !ps2_clk) begin
                if (fall_cnt == 10) begin
                    fall_cnt   = 0;
                    frame_wait = 3;
                end else begin
                    fall_cnt++;
                end
            end
            ps2_prev = ps2_clk;
        end
    end

    // outputs are all registered, stable at the falling edge
    always @(negedge CLOCK_50) begin
        check_value("console_strobe", 64'(strobe_exp), 64'(console_strobe));
        if (con_data_valid) begin
            check_value("console_data", 64'(con_data_exp), 64'(console_data));
        end
        check_value("cpu_tick", 64'(tick_exp), 64'(cpu_tick));
        check_value("LEDR9", 64'(hb_exp), 64'(ledr9));
        check_value("LEDG", 64'(key_model), 64'(ledg));
        check_value("irq_vector", 64'(irq_model), 64'(irq_vector));
        check_value("LEDR7", 64'(irq_model != '0), 64'(ledr7));
        if (rd_pending && rd_known) begin
            check_value("bus_rdata", rd_exp, bus_rdata);
        end
    end

endmodule

`default_nettype wire

//--- testbench/cpu_board_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_board_tb;

    localparam int divide    = 8;
    localparam int mem_words = 64;
    // ps2 clock half period in system cycles
    localparam int ps2_half  = 4;
    localparam int frame_cycles = 11 * 2 * ps2_half + 16;
    // worst row is a break, two frames plus settle
    localparam int row_cycles = 2 * frame_cycles + 32;

    typedef enum logic [2:0] {
        k_write,
        k_read,
        k_console,
        k_make,
        k_break,
        k_bad,
        k_ack,
        k_idle
    } kind_t;

    // one stimulus row, code for key rows sits in data[7:0]
    typedef struct packed {
        kind_t           kind;
        logic [63:0]     addr;
        logic [63:0]     data;
        logic [8*16-1:0] name;
    } row_t;

    logic                         CLOCK_50 = 1'b0;
    logic                         KEY0;
    logic                         PS2_CLK;
    logic                         PS2_DAT;
    logic                         irq_ack;
    board_pkg::bus_req_t          bus_req;
    logic [63:0]                  bus_rdata;
    board_pkg::irq_vector_t       irq_vector;
    logic                         console_strobe;
    logic [7:0]                   console_data;
    logic [7:0]                   LEDG;
    logic                         LEDR9;
    logic                         LEDR7;
    logic                         cpu_tick;
    logic [8*16-1:0]              test_name;
    logic [7:0]                   frame_code;
    logic                         frame_is_make;
    int                           mismatch_count;
    int                           other_errors = 0;
    int                           assert_failures;
    int                           cycle_count = 0;
    int                           cycle_limit = 0;
    logic [63:0]                  addrs [8];
    row_t                         rows [$];

    cpu_board_top #(
        .DIVIDE   (divide),
        .MEM_WORDS(mem_words)
    ) i_dut (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .PS2_CLK       (PS2_CLK),
        .PS2_DAT       (PS2_DAT),
        .bus_req       (bus_req),
        .irq_ack       (irq_ack),
        .bus_rdata     (bus_rdata),
        .irq_vector    (irq_vector),
        .console_strobe(console_strobe),
        .console_data  (console_data),
        .LEDG          (LEDG),
        .LEDR9         (LEDR9),
        .LEDR7         (LEDR7),
        .cpu_tick      (cpu_tick)
    );

    cpu_board_checker #(
        .DIVIDE   (divide),
        .MEM_WORDS(mem_words)
    ) i_checker (
        .CLOCK_50      (CLOCK_50),
        .KEY0          (KEY0),
        .bus_req       (bus_req),
        .irq_ack       (irq_ack),
        .ps2_clk       (PS2_CLK),
        .frame_code    (frame_code),
        .frame_is_make (frame_is_make),
        .test_name     (test_name),
        .bus_rdata     (bus_rdata),
        .irq_vector    (irq_vector),
        .console_strobe(console_strobe),
        .console_data  (console_data),
        .ledg          (LEDG),
        .ledr9         (LEDR9),
        .ledr7         (LEDR7),
        .cpu_tick      (cpu_tick),
        .error_count   (mismatch_count)
    );

    // 100 ns period
    always #50 CLOCK_50 = ~CLOCK_50;

    // run length guard
    always @(posedge CLOCK_50) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    function automatic void add_row(input kind_t kind, input logic [63:0] addr,
                                    input logic [63:0] data, input logic [8*16-1:0] name);
        row_t r;
        r.kind = kind;
        r.addr = addr;
        r.data = data;
        r.name = name;
        rows.push_back(r);
    endfunction

    // one bus cycle, driven on the falling edge
    task automatic drive_bus(input logic we, input logic re, input logic [63:0] addr,
                             input logic [63:0] data);
        @(negedge CLOCK_50);
        bus_req.we      = we;
        bus_req.re      = re;
        bus_req.address = addr;
        bus_req.wdata   = data;
    endtask

    // start, 8 data lsb first, odd parity, stop
    task automatic send_frame(input logic [7:0] code, input logic corrupt);
        logic [10:0] bits;
        logic        parity;
        parity = ~(^code) ^ corrupt;
        bits   = {1'b1, parity, code, 1'b0};
        @(negedge CLOCK_50);
        for (int i = 0; i < 11; i++) begin
            PS2_DAT = bits[i];
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b0;
            repeat (ps2_half) @(negedge CLOCK_50);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
    endtask

    // bounded wait for the irq led
    task automatic wait_irq_led(input logic level, input string what);
        int n;
        n = 0;
        while (LEDR7 !== level && n < 16) begin
            @(negedge CLOCK_50);
            n++;
        end
        if (LEDR7 !== level) begin
            other_errors++;
            $display("%0s: irq led did not go %0s in time", what, level ? "high" : "low");
        end
    endtask

    task automatic run_row(input row_t r);
        @(negedge CLOCK_50);
        test_name = r.name;
        case (r.kind)
            k_write: begin
                drive_bus(1'b1, 1'b0, r.addr, r.data);
                drive_bus(1'b0, 1'b0, 64'h0, 64'h0);
            end
            k_read: begin
                drive_bus(1'b0, 1'b1, r.addr, 64'h0);
                drive_bus(1'b0, 1'b0, 64'h0, 64'h0);
                repeat (2) @(negedge CLOCK_50);
            end
            k_console: begin
                // run of three back to back writes
                for (int i = 0; i < 3; i++) begin
                    drive_bus(1'b1, 1'b0, board_pkg::console_addr, r.data + 64'(i));
                end
                drive_bus(1'b0, 1'b0, 64'h0, 64'h0);
                repeat (3) @(negedge CLOCK_50);
            end
            k_make: begin
                frame_code    = r.data[7:0];
                frame_is_make = 1'b1;
                send_frame(r.data[7:0], 1'b0);
                wait_irq_led(1'b1, "key make");
            end
            k_break: begin
                frame_is_make = 1'b0;
                frame_code    = board_pkg::break_prefix;
                send_frame(board_pkg::break_prefix, 1'b0);
                repeat (8) @(negedge CLOCK_50);
                frame_code = r.data[7:0];
                send_frame(r.data[7:0], 1'b0);
                repeat (8) @(negedge CLOCK_50);
            end
            k_bad: begin
                frame_is_make = 1'b0;
                frame_code    = r.data[7:0];
                send_frame(r.data[7:0], 1'b1);
                repeat (8) @(negedge CLOCK_50);
            end
            k_ack: begin
                irq_ack = 1'b1;
                wait_irq_led(1'b0, "acknowledge");
                irq_ack = 1'b0;
                repeat (2) @(negedge CLOCK_50);
            end
            default: begin
                repeat (r.data) @(negedge CLOCK_50);
            end
        endcase
    endtask

    task automatic build_table();
        add_row(k_idle, 64'h0, 64'd24, "reset_tick");
        for (int i = 0; i < 8; i++) begin
            addrs[i] = 64'(($urandom % mem_words) * 4);
            add_row(k_write, addrs[i], {$urandom, $urandom}, "mem_write");
        end
        for (int i = 0; i < 8; i++) begin
            add_row(k_read, addrs[i], 64'h0, "mem_read");
        end
        add_row(k_write, 64'h8000, 64'h1234, "unmapped_write");
        add_row(k_read, 64'h8000, 64'h0, "unmapped_read");
        add_row(k_console, board_pkg::console_addr, 64'h41, "console_run");
        add_row(k_make, 64'h0, 64'h1C, "key_make");
        add_row(k_read, board_pkg::key_addr, 64'h0, "key_read");
        add_row(k_ack, 64'h0, 64'h0, "irq_ack");
        add_row(k_break, 64'h0, 64'h32, "key_break");
        add_row(k_read, board_pkg::key_addr, 64'h0, "key_after_break");
        add_row(k_bad, 64'h0, 64'h2B, "bad_parity");
        add_row(k_read, board_pkg::key_addr, 64'h0, "key_after_bad");
        add_row(k_make, 64'h0, 64'h23, "key_make_2");
        add_row(k_ack, 64'h0, 64'h0, "irq_ack_2");
    endtask

    initial begin
        void'($urandom(5738));
        KEY0          = 1'b0;
        PS2_CLK       = 1'b1;
        PS2_DAT       = 1'b1;
        irq_ack       = 1'b0;
        bus_req       = '0;
        test_name     = "reset";
        frame_code    = 8'h00;
        frame_is_make = 1'b0;
        build_table();
        cycle_limit = rows.size() * row_cycles + 100;
        // reset held for two cycles
        repeat (2) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        KEY0 = 1'b1;
        foreach (rows[i]) begin
            run_row(rows[i]);
        end
        repeat (4) @(negedge CLOCK_50);
        assert_failures = i_dut.i_bus_decoder.i_decoder_assertions.failures
                        + i_dut.i_interrupt_controller.i_irq_assertions.failures;
        $display("errors: %0d mismatch, %0d other, %0d assertion",
                 mismatch_count, other_errors, assert_failures);
        if (mismatch_count == 0 && other_errors == 0 && assert_failures == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cpu_board_top.f
src/board_pkg.sv
src/clock_divider.sv
src/ps2_receiver.sv
src/board_memory.sv
src/bus_decoder.sv
src/interrupt_controller.sv
src/cpu_board_top.sv
testbench/cpu_board_assertions.sv
testbench/cpu_board_checker.sv
testbench/cpu_board_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the cpu board testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cpu_board_tb \
    -f cpu_board_top.f \
    -o cpu_board_sim

./obj_dir/cpu_board_sim | tee sim.log

if grep -q "Result: PASSED" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
